//--- pmp_pkg.sv
// Shared constants and types for the PMP unit.
// Wishbone addresses are word addresses; the low two bits select a register
// and the upper bits select a region, so at most 16 regions are reachable.
// Flag bits follow the {valid, lock, read, write, execute} order.

package pmp_pkg;

    // Wishbone port widths
    localparam int WB_DATA_BITS = 32;
    localparam int WB_ADDR_BITS = 6;    // Word address

    // Register selector, low two bits of the word address
    localparam logic [1:0] REG_START = 2'd0;    // Inclusive start address
    localparam logic [1:0] REG_END   = 2'd1;    // Inclusive end address
    localparam logic [1:0] REG_FLAGS = 2'd2;
    localparam logic [1:0] REG_FAULT = 2'd3;    // Fault record, regions 0 and 1 only

    // Flag bit positions inside one region's flags field
    localparam int FL_V = 4;    // Region valid
    localparam int FL_L = 3;    // Locked, checked even with protection off
    localparam int FL_R = 2;
    localparam int FL_W = 1;
    localparam int FL_X = 0;

    // Width of one region's flags in the flat table
    localparam int FL_BITS = FL_V + 1;

    // Flags as they appear in a write to REG_FLAGS
    typedef struct packed {
        logic [26:0] pad;
        logic        valid;
        logic        lock;
        logic        read;
        logic        write;
        logic        execute;
    } pmp_flags_t;

    // One write word, seen as an address or as flags
    // depending on the register selector
    typedef union packed {
        logic [WB_DATA_BITS-1:0] addr;
        pmp_flags_t              flags;
    } pmp_wdata_u;

endpackage

//--- pmp_region_cfg.sv
// Wishbone classic slave holding the PMP region table.
// Ack comes one cycle after a request and never two cycles running.
// REG_FAULT of region 0 reads {valid, cause} and a write there clears the record;
// REG_FAULT of region 1 reads the fault address. Other REG_FAULT slots read zero.

`timescale 1ns/1ps

module pmp_region_cfg #(
    parameter int ADDR_BITS   = 32,
    parameter int NUM_REGIONS = 8
) (
    input  logic                               i_clk,
    input  logic                               i_nrst,
    input  logic                               i_wb_cyc,
    input  logic                               i_wb_stb,
    input  logic                               i_wb_we,
    input  logic [pmp_pkg::WB_ADDR_BITS-1:0]   i_wb_adr,
    input  logic [pmp_pkg::WB_DATA_BITS-1:0]   i_wb_dat,
    input  logic                               i_fault_valid,
    input  logic [1:0]                         i_fault_cause,
    input  logic [ADDR_BITS-1:0]               i_fault_addr,
    output logic [pmp_pkg::WB_DATA_BITS-1:0]   o_wb_dat,
    output logic                               o_wb_ack,
    output logic [NUM_REGIONS*ADDR_BITS-1:0]   o_tbl_start,
    output logic [NUM_REGIONS*ADDR_BITS-1:0]   o_tbl_end,
    output logic [NUM_REGIONS*pmp_pkg::FL_BITS-1:0] o_tbl_flags,
    output logic                               o_fault_clear
);

    import pmp_pkg::*;

    localparam int SEL_BITS = WB_ADDR_BITS - 2;

    logic [ADDR_BITS-1:0]    tbl_start [NUM_REGIONS];
    logic [ADDR_BITS-1:0]    tbl_end   [NUM_REGIONS];
    logic [FL_BITS-1:0]      tbl_flags [NUM_REGIONS];

    pmp_wdata_u              wdata;
    logic                    req;
    logic                    wr_en;
    logic [1:0]              reg_sel;
    logic [SEL_BITS-1:0]     rgn_sel;
    logic [WB_DATA_BITS-1:0] rdata;

    assign wdata   = i_wb_dat;
    assign req     = i_wb_cyc & i_wb_stb & ~o_wb_ack;   // New request, not yet acked
    assign wr_en   = req & i_wb_we;
    assign reg_sel = i_wb_adr[1:0];
    assign rgn_sel = i_wb_adr[WB_ADDR_BITS-1:2];

    // Record clear lands on the same edge as the ack
    assign o_fault_clear = wr_en && (rgn_sel == '0) && (reg_sel == REG_FAULT);

    // Table writes
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < NUM_REGIONS; i++) begin
                tbl_start[i] <= '0;
                tbl_end[i]   <= '0;
                tbl_flags[i] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < NUM_REGIONS; i++) begin
                if (int'(rgn_sel) == i) begin
                    case (reg_sel)
                        REG_START: tbl_start[i] <= wdata.addr[ADDR_BITS-1:0];
                        REG_END:   tbl_end[i]   <= wdata.addr[ADDR_BITS-1:0];
                        REG_FLAGS: begin
                            tbl_flags[i] <= {wdata.flags.valid, wdata.flags.lock,
                                             wdata.flags.read, wdata.flags.write,
                                             wdata.flags.execute};
                            // Dropping valid also removes the range
                            if (!wdata.flags.valid) begin
                                tbl_start[i] <= '0;
                                tbl_end[i]   <= '0;
                            end
                        end
                        default: ;  // REG_FAULT handled by the fault unit
                    endcase
                end
            end
        end
    end

    // Read mux
    always_comb begin
        rdata = '0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (int'(rgn_sel) == i) begin
                case (reg_sel)
                    REG_START: rdata[ADDR_BITS-1:0] = tbl_start[i];
                    REG_END:   rdata[ADDR_BITS-1:0] = tbl_end[i];
                    REG_FLAGS: rdata[FL_BITS-1:0]   = tbl_flags[i];
                    default:   ;
                endcase
            end
        end
        if (reg_sel == REG_FAULT) begin
            if (rgn_sel == SEL_BITS'(0)) begin
                rdata[WB_DATA_BITS-1] = i_fault_valid;
                rdata[1:0]            = i_fault_cause;
            end else if (rgn_sel == SEL_BITS'(1)) begin
                rdata[ADDR_BITS-1:0] = i_fault_addr;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= req;
        end
    end

    // Read data held for the ack cycle
    always_ff @(posedge i_clk) begin
        if (req) begin
            o_wb_dat <= rdata;
        end
    end

    // Flatten the table for the matchers
    always_comb begin
        for (int i = 0; i < NUM_REGIONS; i++) begin
            o_tbl_start[i*ADDR_BITS +: ADDR_BITS] = tbl_start[i];
            o_tbl_end[i*ADDR_BITS +: ADDR_BITS]   = tbl_end[i];
            o_tbl_flags[i*FL_BITS +: FL_BITS]     = tbl_flags[i];
        end
    end

endmodule

//--- pmp_region_match.sv
// Combinational region lookup for one address.
// Bounds are inclusive. The lowest matching valid region decides.
// With no applicable region the access is allowed only when i_ena is low.

`timescale 1ns/1ps

module pmp_region_match #(
    parameter int ADDR_BITS   = 32,
    parameter int NUM_REGIONS = 8
) (
    input  logic [ADDR_BITS-1:0]                     i_addr,
    input  logic                                     i_ena,
    input  logic [NUM_REGIONS*ADDR_BITS-1:0]         i_tbl_start,
    input  logic [NUM_REGIONS*ADDR_BITS-1:0]         i_tbl_end,
    input  logic [NUM_REGIONS*pmp_pkg::FL_BITS-1:0]  i_tbl_flags,
    output logic                                     o_r,
    output logic                                     o_w,
    output logic                                     o_x
);

    import pmp_pkg::*;

    always_comb begin
        logic [ADDR_BITS-1:0] rgn_start;
        logic [ADDR_BITS-1:0] rgn_end;
        logic [FL_BITS-1:0]   rgn_flags;
        logic                 in_range;
        logic                 applies;

        // Default when nothing matches
        o_r = ~i_ena;
        o_w = ~i_ena;
        o_x = ~i_ena;

        // Walk down so a lower index overrides a higher one
        for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
            rgn_start = i_tbl_start[i*ADDR_BITS +: ADDR_BITS];
            rgn_end   = i_tbl_end[i*ADDR_BITS +: ADDR_BITS];
            rgn_flags = i_tbl_flags[i*FL_BITS +: FL_BITS];

            in_range = (i_addr >= rgn_start) && (i_addr <= rgn_end);
            // Locked regions are enforced even with protection off
            applies  = rgn_flags[FL_V] && (i_ena || rgn_flags[FL_L]);

            if (in_range && applies) begin
                o_r = rgn_flags[FL_R];
                o_w = rgn_flags[FL_W];
                o_x = rgn_flags[FL_X];
            end
        end
    end

endmodule

//--- pmp_fault_unit.sv
// Fault outputs are combinational from the strobes and permissions.
// The record holds the first fault only, fetch before load before store,
// until i_clear. A clear wins over a capture in the same cycle.

`timescale 1ns/1ps

module pmp_fault_unit #(
    parameter int ADDR_BITS = 32
) (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  logic                 i_fetch_req,
    input  logic                 i_load_req,
    input  logic                 i_store_req,
    input  logic [ADDR_BITS-1:0] i_iaddr,
    input  logic [ADDR_BITS-1:0] i_daddr,
    input  logic                 i_fetch_x,
    input  logic                 i_data_r,
    input  logic                 i_data_w,
    input  logic                 i_clear,
    output logic                 o_fetch_fault,
    output logic                 o_load_fault,
    output logic                 o_store_fault,
    output logic                 o_fault_valid,
    output logic [1:0]           o_fault_cause,
    output logic [ADDR_BITS-1:0] o_fault_addr
);

    // Cause encoding as read back over Wishbone
    localparam logic [1:0] CAUSE_FETCH = 2'd1;
    localparam logic [1:0] CAUSE_LOAD  = 2'd2;
    localparam logic [1:0] CAUSE_STORE = 2'd3;

    logic any_fault;

    assign o_fetch_fault = i_fetch_req & ~i_fetch_x;
    assign o_load_fault  = i_load_req  & ~i_data_r;
    assign o_store_fault = i_store_req & ~i_data_w;

    assign any_fault = o_fetch_fault | o_load_fault | o_store_fault;

    // Sticky record of the first fault
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_fault_valid <= 1'b0;
            o_fault_cause <= '0;
            o_fault_addr  <= '0;
        end else if (i_clear) begin
            o_fault_valid <= 1'b0;
            o_fault_cause <= '0;
            o_fault_addr  <= '0;
        end else if (!o_fault_valid && any_fault) begin
            o_fault_valid <= 1'b1;
            if (o_fetch_fault) begin
                o_fault_cause <= CAUSE_FETCH;
                o_fault_addr  <= i_iaddr;
            end else if (o_load_fault) begin
                o_fault_cause <= CAUSE_LOAD;
                o_fault_addr  <= i_daddr;
            end else begin
                o_fault_cause <= CAUSE_STORE;
                o_fault_addr  <= i_daddr;
            end
        end
    end

endmodule

//--- pmp_top.sv
// PMP unit top level with a Wishbone classic configuration port.
// ADDR_BITS must be at most 32; NUM_REGIONS a power of two, at most 16.
// Checks are combinational; table writes are seen the cycle after ack.

`timescale 1ns/1ps

module pmp_top #(
    parameter int ADDR_BITS   = 32,
    parameter int NUM_REGIONS = 8
) (
    input  logic                             i_clk,
    input  logic                             i_nrst,
    input  logic                             i_wb_cyc,
    input  logic                             i_wb_stb,
    input  logic                             i_wb_we,
    input  logic [pmp_pkg::WB_ADDR_BITS-1:0] i_wb_adr,
    input  logic [pmp_pkg::WB_DATA_BITS-1:0] i_wb_dat,
    input  logic                             i_ena,
    input  logic [ADDR_BITS-1:0]             i_iaddr,
    input  logic [ADDR_BITS-1:0]             i_daddr,
    input  logic                             i_fetch_req,
    input  logic                             i_load_req,
    input  logic                             i_store_req,
    output logic [pmp_pkg::WB_DATA_BITS-1:0] o_wb_dat,
    output logic                             o_wb_ack,
    output logic                             o_fetch_fault,
    output logic                             o_load_fault,
    output logic                             o_store_fault
);

    import pmp_pkg::*;

    logic [NUM_REGIONS*ADDR_BITS-1:0] tbl_start;
    logic [NUM_REGIONS*ADDR_BITS-1:0] tbl_end;
    logic [NUM_REGIONS*FL_BITS-1:0]   tbl_flags;
    logic                             fetch_x;
    logic                             data_r;
    logic                             data_w;
    logic                             fault_valid;
    logic [1:0]                       fault_cause;
    logic [ADDR_BITS-1:0]             fault_addr;
    logic                             fault_clear;

    pmp_region_cfg #(
        .ADDR_BITS   (ADDR_BITS),
        .NUM_REGIONS (NUM_REGIONS)
    ) u_cfg (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_wb_cyc      (i_wb_cyc),
        .i_wb_stb      (i_wb_stb),
        .i_wb_we       (i_wb_we),
        .i_wb_adr      (i_wb_adr),
        .i_wb_dat      (i_wb_dat),
        .i_fault_valid (fault_valid),
        .i_fault_cause (fault_cause),
        .i_fault_addr  (fault_addr),
        .o_wb_dat      (o_wb_dat),
        .o_wb_ack      (o_wb_ack),
        .o_tbl_start   (tbl_start),
        .o_tbl_end     (tbl_end),
        .o_tbl_flags   (tbl_flags),
        .o_fault_clear (fault_clear)
    );

    // Instruction side, execute permission only
    pmp_region_match #(
        .ADDR_BITS   (ADDR_BITS),
        .NUM_REGIONS (NUM_REGIONS)
    ) u_fetch_match (
        .i_addr      (i_iaddr),
        .i_ena       (i_ena),
        .i_tbl_start (tbl_start),
        .i_tbl_end   (tbl_end),
        .i_tbl_flags (tbl_flags),
        .o_r         (),
        .o_w         (),
        .o_x         (fetch_x)
    );

    // Data side, read and write permission
    pmp_region_match #(
        .ADDR_BITS   (ADDR_BITS),
        .NUM_REGIONS (NUM_REGIONS)
    ) u_data_match (
        .i_addr      (i_daddr),
        .i_ena       (i_ena),
        .i_tbl_start (tbl_start),
        .i_tbl_end   (tbl_end),
        .i_tbl_flags (tbl_flags),
        .o_r         (data_r),
        .o_w         (data_w),
        .o_x         ()
    );

    pmp_fault_unit #(
        .ADDR_BITS (ADDR_BITS)
    ) u_fault (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_fetch_req   (i_fetch_req),
        .i_load_req    (i_load_req),
        .i_store_req   (i_store_req),
        .i_iaddr       (i_iaddr),
        .i_daddr       (i_daddr),
        .i_fetch_x     (fetch_x),
        .i_data_r      (data_r),
        .i_data_w      (data_w),
        .i_clear       (fault_clear),
        .o_fetch_fault (o_fetch_fault),
        .o_load_fault  (o_load_fault),
        .o_store_fault (o_store_fault),
        .o_fault_valid (fault_valid),
        .o_fault_cause (fault_cause),
        .o_fault_addr  (fault_addr)
    );

endmodule

//--- pmp_properties.sv
// Assertions on the Wishbone handshake and the fault outputs.
// Bound to pmp_region_cfg and pmp_fault_unit; inputs a target lacks are tied low.

`timescale 1ns/1ps

module pmp_properties (
    input logic       i_clk,
    input logic       i_nrst,
    input logic       i_cyc,
    input logic       i_stb,
    input logic       i_ack,
    input logic [2:0] i_req,      // {fetch, load, store}
    input logic [2:0] i_fault     // Same order as i_req
);

    // Ack is a single-cycle pulse
    ack_single: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_ack |=> !i_ack)
        else $error("Wishbone ack held high for two cycles");

    // Ack answers a request seen on the previous edge
    ack_after_req: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_ack |-> $past(i_cyc && i_stb))
        else $error("Wishbone ack without a preceding request");

    fault_needs_req: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_fault & ~i_req) == 3'b000)
        else $error("Fault output raised without its access request");

endmodule

//--- tb_pmp_top.sv
// Testbench for pmp_top. Inputs change on the falling edge of the clock.
// Expected faults come from a reference copy of the region table kept here.
// Assumes the default 32-bit addresses and 8 regions.

`timescale 1ns/1ps

module tb_pmp_top;

    import pmp_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_REGIONS  = 8;
    localparam int NUM_ENTRIES  = 20;
    localparam int SETUP_CYCLES = 150;  // Reset, programming and readbacks

    // Flag words in {valid, lock, read, write, execute} order
    localparam logic [4:0] F_V = 5'b10000;
    localparam logic [4:0] F_L = 5'b01000;
    localparam logic [4:0] F_R = 5'b00100;
    localparam logic [4:0] F_W = 5'b00010;
    localparam logic [4:0] F_X = 5'b00001;

    logic        i_clk;
    logic        i_nrst;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [5:0]  i_wb_adr;
    logic [31:0] i_wb_dat;
    logic        i_ena;
    logic [31:0] i_iaddr;
    logic [31:0] i_daddr;
    logic        i_fetch_req;
    logic        i_load_req;
    logic        i_store_req;
    logic [31:0] o_wb_dat;
    logic        o_wb_ack;
    logic        o_fetch_fault;
    logic        o_load_fault;
    logic        o_store_fault;

    string       t_name  [NUM_ENTRIES];
    logic        t_ena   [NUM_ENTRIES];
    logic [31:0] t_iaddr [NUM_ENTRIES];
    logic [31:0] t_daddr [NUM_ENTRIES];
    logic [2:0]  t_req   [NUM_ENTRIES];     // {fetch, load, store}
    logic [2:0]  t_exp   [NUM_ENTRIES];     // Expected faults, same order
    int          n_entries;
    int          next_run;

    logic [31:0] m_start [NUM_REGIONS];     // Reference table
    logic [31:0] m_end   [NUM_REGIONS];
    logic [4:0]  m_flags [NUM_REGIONS];

    integer      seed = 32'hb4b5_27da;
    int          n_tests;
    int          n_fail;
    logic [31:0] rd;

    pmp_top #(
        .ADDR_BITS   (32),
        .NUM_REGIONS (NUM_REGIONS)
    ) dut0 (.*);

    bind pmp_region_cfg pmp_properties u_wb_props (
        .i_clk (i_clk), .i_nrst (i_nrst), .i_cyc (i_wb_cyc), .i_stb (i_wb_stb),
        .i_ack (o_wb_ack), .i_req (3'b000), .i_fault (3'b000)
    );
    bind pmp_fault_unit pmp_properties u_fault_props (
        .i_clk (i_clk), .i_nrst (i_nrst), .i_cyc (1'b0), .i_stb (1'b0), .i_ack (1'b0),
        .i_req ({i_fetch_req, i_load_req, i_store_req}),
        .i_fault ({o_fetch_fault, o_load_fault, o_store_fault})
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // {r, w, x} for one address, lowest applicable region first
    function automatic logic [2:0] ref_perm(input logic [31:0] addr, input logic ena);
        logic [2:0] perm;
        logic       found;
        perm  = {3{~ena}};
        found = 1'b0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (!found && m_flags[i][4] && (ena || m_flags[i][3])
                    && addr >= m_start[i] && addr <= m_end[i]) begin
                perm  = m_flags[i][2:0];
                found = 1'b1;
            end
        end
        return perm;
    endfunction

    task automatic add_entry(input string name, input logic ena, input logic [31:0] ia,
                             input logic [31:0] da, input logic [2:0] req);
        logic [2:0] pi;
        logic [2:0] pd;
        pi = ref_perm(ia, ena);
        pd = ref_perm(da, ena);
        t_name[n_entries]  = name;
        t_ena[n_entries]   = ena;
        t_iaddr[n_entries] = ia;
        t_daddr[n_entries] = da;
        t_req[n_entries]   = req;
        t_exp[n_entries]   = req & {~pi[0], ~pd[2], ~pd[1]};   // Missing x, r, w
        n_entries++;
    endtask

    task automatic wb_access(input logic we, input logic [5:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata);
        int n;
        @(negedge i_clk);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = dat;
        n = 0;
        @(negedge i_clk);
        while (!o_wb_ack && n < 3) begin
            @(negedge i_clk);
            n++;
        end
        rdata = o_wb_dat;
        if (!o_wb_ack) begin
            $display("No ack from the Wishbone slave within 4 cycles, address %h", adr);
            n_fail++;
        end
        i_wb_cyc = 1'b0;   // Dropped in the ack cycle
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic reg_write(input int rgn, input logic [1:0] sel, input logic [31:0] dat);
        logic [31:0] ignored;
        wb_access(1'b1, {rgn[3:0], sel}, dat, ignored);
        case (sel)
            REG_START: m_start[rgn] = dat;
            REG_END:   m_end[rgn] = dat;
            REG_FLAGS: begin
                m_flags[rgn] = dat[4:0];
                if (!dat[4]) begin
                    m_start[rgn] = '0;
                    m_end[rgn]   = '0;
                end
            end
            default: ;
        endcase
    endtask

    task automatic reg_read(input int rgn, input logic [1:0] sel, output logic [31:0] data);
        wb_access(1'b0, {rgn[3:0], sel}, 32'h0, data);
    endtask

    task automatic program_region(input int rgn, input logic [31:0] s, input logic [31:0] e,
                                  input logic [4:0] fl);
        reg_write(rgn, REG_START, s);
        reg_write(rgn, REG_END, e);
        reg_write(rgn, REG_FLAGS, {27'h0, fl});
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_tests++;
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            n_fail++;
        end else begin
            $display("ok   %s", name);
        end
    endtask

    // Apply every table entry added since the last call
    task automatic run_pending();
        logic [2:0] act;
        for (int k = next_run; k < n_entries; k++) begin
            @(negedge i_clk);
            i_ena   = t_ena[k];
            i_iaddr = t_iaddr[k];
            i_daddr = t_daddr[k];
            {i_fetch_req, i_load_req, i_store_req} = t_req[k];
            @(posedge i_clk);
            act = {o_fetch_fault, o_load_fault, o_store_fault};
            n_tests++;
            if (act !== t_exp[k]) begin
                $display("Mismatch %s: expected faults %b, actual %b", t_name[k], t_exp[k], act);
                n_fail++;
            end else begin
                $display("ok   %s", t_name[k]);
            end
        end
        next_run = n_entries;
        @(negedge i_clk);
        {i_fetch_req, i_load_req, i_store_req} = 3'b000;
    endtask

    initial begin
        #((NUM_ENTRIES * 10 + SETUP_CYCLES) * CLK_PERIOD);
        $display("Watchdog timeout, the test sequence did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        i_clk = 1'b0;
        i_nrst = 1'b0;
        {i_wb_cyc, i_wb_stb, i_wb_we, i_wb_adr, i_wb_dat} = '0;
        {i_ena, i_iaddr, i_daddr} = '0;
        {i_fetch_req, i_load_req, i_store_req} = 3'b000;
        {n_entries, next_run, n_tests, n_fail} = '0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            m_start[i] = '0;
            m_end[i]   = '0;
            m_flags[i] = '0;
        end
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;

        // Empty table, only i_ena decides
        add_entry("rst_ena_on", 1'b1, $random(seed), $random(seed), 3'b111);
        add_entry("rst_ena_off", 1'b0, $random(seed), $random(seed), 3'b111);
        run_pending();

        // Overlapping regions, region 1 read only
        program_region(1, 32'h1000, 32'h1fff, F_V | F_R);
        program_region(3, 32'h1800, 32'h2fff, F_V | F_R | F_W | F_X);
        add_entry("r1_lo_bound", 1'b1, 32'h1000, 32'h1000, 3'b111);
        add_entry("r1_hi_bound", 1'b1, 32'h1fff, 32'h1fff, 3'b111);
        add_entry("below_r1", 1'b1, 32'h0fff, 32'h0fff, 3'b111);
        add_entry("overlap_lo", 1'b1, 32'h1800, 32'h1800, 3'b111);
        add_entry("r3_past_r1", 1'b1, 32'h2000, 32'h2000, 3'b111);
        add_entry("r3_hi_bound", 1'b1, 32'h2fff, 32'h2fff, 3'b111);
        add_entry("above_r3", 1'b1, 32'h3000, 32'h3000, 3'b111);
        add_entry("split_fetch_ok", 1'b1, 32'h2100, 32'h1100, 3'b111);
        add_entry("split_data_ok", 1'b1, 32'h1100, 32'h2100, 3'b111);
        add_entry("random_a", 1'b1, $random(seed) & 32'h3fff, $random(seed) & 32'h3fff, 3'b111);
        add_entry("random_b", 1'b1, $random(seed) & 32'h3fff, $random(seed) & 32'h3fff, 3'b111);
        run_pending();

        program_region(0, 32'h8000, 32'h8fff, F_V | F_L | F_R);
        add_entry("locked_ena_off", 1'b0, 32'h8100, 32'h8100, 3'b111);
        add_entry("unlocked_ena_off", 1'b0, 32'h1000, 32'h1000, 3'b111);
        add_entry("locked_ena_on", 1'b1, 32'h8fff, 32'h8fff, 3'b111);
        run_pending();

        // Clearing valid drops region 3 and its range
        reg_write(3, REG_FLAGS, 32'h0);
        reg_read(3, REG_START, rd);
        check_word("r3_start_cleared", 32'h0, rd);
        reg_read(3, REG_END, rd);
        check_word("r3_end_cleared", 32'h0, rd);
        add_entry("r3_removed", 1'b1, 32'h2000, 32'h2000, 3'b111);
        add_entry("r3_removed_ena_off", 1'b0, 32'h2000, 32'h2000, 3'b111);
        run_pending();

        // Fault record keeps only the first fault
        reg_write(0, REG_FAULT, 32'h0);
        add_entry("rec_store", 1'b1, 32'h0, 32'h1200, 3'b001);
        add_entry("rec_fetch", 1'b1, 32'h5000, 32'h0, 3'b100);
        run_pending();
        reg_read(0, REG_FAULT, rd);
        check_word("rec_cause", 32'h8000_0003, rd);
        reg_read(1, REG_FAULT, rd);
        check_word("rec_addr", 32'h0000_1200, rd);
        reg_write(0, REG_FAULT, 32'h0);
        reg_read(0, REG_FAULT, rd);
        check_word("rec_cleared", 32'h0, rd);

        $display("Tests: %0d run, %0d failed", n_tests, n_fail);
        if (n_fail == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- pmp_top.f
pmp_pkg.sv
pmp_region_cfg.sv
pmp_region_match.sv
pmp_fault_unit.sv
pmp_top.sv
pmp_properties.sv
tb_pmp_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PMP testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pmp_top -f pmp_top.f -o sim_pmp
./obj_dir/sim_pmp | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "Run passed"
else
    echo "Run failed"
    exit 1
fi
